/* list.f */
+incdir+hw
hw/usiPkg.sv
hw/usiBus.sv
hw/usiGpio.sv
hw/usiPwm.sv
hw/usiRam.sv
hw/usiTop.sv
dv/usiTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module usiTb --Mdir "$BUILD_DIR"

"./$BUILD_DIR/VusiTb" | tee "$LOG"

if grep -qx "TB PASSED" "$LOG"; then
	echo "Simulation passed"
else
	echo "Simulation failed, see $LOG"
	exit 1
fi

/* dv/usiTb.sv */
// Testbench for the peripheral subsystem
// Clock, reset, bus stimulus and response model
// Concurrent checks on mRd and mREd and a watchdog
`timescale 1ns/1ps
`default_nettype none
`include "usi_settings.svh"

module usiTb;
	import usiPkg::*;

	localparam int ClkPeriod  = 100;
	localparam int PipeDepth  = 3;                        // Edges from command to mRd
	localparam int MinPeriod  = 4;                        // Smallest random PWM period
	localparam int MaxPeriod  = 20;                       // Largest random PWM period
	localparam int RamIdxBits = $clog2(`USI_RAM_DEPTH);
	// Cycles for reset, GPIO, RAM, three PWM cases, unmapped and drain
	localparam int TestCycles = 8 + 16 + 2 * `USI_RAM_DEPTH + 3 * (2 * MaxPeriod + 12) + 24;

	typedef struct packed
	{
		logic                      isRead;
		logic [`USI_DATA_BITS-1:0] data;
		logic [`USI_SLAVES-1:0]    rdy;
	} respT;

	// DUT ports
	logic                      iUsiClk;
	logic                      rstN;
	logic [`USI_DATA_BITS-1:0] mWd;
	logic [`USI_ADRS_BITS-1:0] mAdrs;
	logic                      mWEd;
	logic [`USI_DATA_BITS-1:0] mRd;
	logic [`USI_SLAVES-1:0]    mREd;
	logic [`USI_GPIO_BITS-1:0] gpioIn;
	logic [`USI_GPIO_BITS-1:0] gpioOut;
	logic                      pwmOut;

	// Reference model state
	respT                      respQ [$];                 // One entry per cycle
	logic [`USI_DATA_BITS-1:0] expRd  = '0;
	logic [`USI_SLAVES-1:0]    expREd = '0;
	logic [`USI_GPIO_BITS-1:0] gpioShadow;
	logic [`USI_DATA_BITS-1:0] pwmPeriod;
	logic [`USI_DATA_BITS-1:0] pwmDuty;
	logic [`USI_DATA_BITS-1:0] ramShadow [`USI_RAM_DEPTH];
	logic [31:0]               rngState = 32'd79;
	logic                      chkOn  = 1'b0;              // Compare against model
	logic                      rstWin = 1'b0;              // Reset values expected

	usiTop i_usiTop (
		.iUsiClk (iUsiClk), .rstN (rstN),
		.mWd     (mWd),     .mAdrs (mAdrs), .mWEd (mWEd),
		.mRd     (mRd),     .mREd  (mREd),
		.gpioIn  (gpioIn),  .gpioOut (gpioOut), .pwmOut (pwmOut)
	);

	initial
	begin
		iUsiClk = 1'b0;
		forever #(ClkPeriod / 2) iUsiClk = ~iUsiClk;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "Run aborted");
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] randWord();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// Shadow registers follow the issue order
	// Response falls due PipeDepth edges later
	task automatic predict(input logic en, input usiCmdE cmd, input usiBlockT blk,
			input usiCsrT csr, input logic [`USI_DATA_BITS-1:0] wd);
		respT r;
		r.isRead = en && cmd == cmdRead;
		r.data   = `USI_FILL;                             // Unmapped block
		r.rdy    = '0;
		if (en && cmd == cmdWrite)
		begin
			case (blk)
				`USI_GPIO_BLOCK: if (csr == 16'd0) gpioShadow = wd[`USI_GPIO_BITS-1:0];
				`USI_PWM_BLOCK:
				begin
					if (csr == 16'd0)
						pwmPeriod = wd;
					if (csr == 16'd1)
						pwmDuty = wd;
				end
				`USI_RAM_BLOCK:  ramShadow[csr[RamIdxBits-1:0]] = wd;
				default: ;                                    // Nobody listens
			endcase
		end
		if (r.isRead)
		begin
			case (blk)
				`USI_GPIO_BLOCK:
				begin
					r.rdy[`USI_GPIO_BLOCK-1] = 1'b1;
					r.data = (csr == 16'd0) ? `USI_DATA_BITS'(gpioShadow) :
						(csr == 16'd1) ? `USI_DATA_BITS'(gpioIn) : '0;
				end
				`USI_PWM_BLOCK:
				begin
					r.rdy[`USI_PWM_BLOCK-1] = 1'b1;
					r.data = (csr == 16'd0) ? pwmPeriod : (csr == 16'd1) ? pwmDuty : '0;
				end
				`USI_RAM_BLOCK:
				begin
					r.rdy[`USI_RAM_BLOCK-1] = 1'b1;
					r.data = ramShadow[csr[RamIdxBits-1:0]];
				end
				default: ;
			endcase
		end
		respQ.push_back(r);
		if (respQ.size() > PipeDepth)
		begin
			r = respQ.pop_front();
			if (r.isRead)
				expRd = r.data;                                 // mRd holds otherwise
			expREd = r.rdy;
		end
	endtask

	// One bus cycle with inputs changed 1 ns after the edge
	task automatic issue(input logic en, input usiCmdE cmd, input usiBlockT blk,
			input usiCsrT csr, input logic [`USI_DATA_BITS-1:0] wd);
		@(posedge iUsiClk);
		#1;
		mWEd  = en;
		mAdrs = {cmd, 6'd0, blk, csr};
		mWd   = wd;
		predict(en, cmd, blk, csr, wd);
	endtask

	task automatic idle(input int n);
		repeat (n) issue(1'b0, cmdNone, 8'd0, 16'd0, '0);
	endtask

	task automatic writeReg(input usiBlockT blk, input usiCsrT csr,
			input logic [`USI_DATA_BITS-1:0] wd);
		issue(1'b1, cmdWrite, blk, csr, wd);
	endtask

	task automatic readReg(input usiBlockT blk, input usiCsrT csr);
		issue(1'b1, cmdRead, blk, csr, '0);
	endtask

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	// Sampled mid-cycle where outputs are settled
	assert property (@(negedge iUsiClk) !chkOn || mRd == expRd)
		else abortRun($sformatf("FAILED at %0d ns: mRd is %h, expected %h",
			$time, mRd, expRd));
	assert property (@(negedge iUsiClk) !chkOn || mREd == expREd)
		else abortRun($sformatf("FAILED at %0d ns: mREd is %b, expected %b",
			$time, mREd, expREd));
	assert property (@(negedge iUsiClk) !rstWin || (mREd == '0 && gpioOut == '0 && !pwmOut))
		else abortRun($sformatf("FAILED at %0d ns: outputs not at reset values", $time));

	task automatic checkGpioOut();
		assert (gpioOut == gpioShadow)
			else abortRun($sformatf("FAILED at %0d ns: gpioOut is %h, expected %h",
				$time, gpioOut, gpioShadow));
	endtask

	task automatic checkGpio();
		logic [`USI_DATA_BITS-1:0] word;
		writeReg(`USI_GPIO_BLOCK, 16'd0, randWord());
		idle(2);                                          // Output register updated
		checkGpioOut();
		readReg(`USI_GPIO_BLOCK, 16'd0);
		writeReg(`USI_GPIO_BLOCK, 16'd0, randWord());    // Readback right after a write
		readReg(`USI_GPIO_BLOCK, 16'd0);
		word   = randWord();
		gpioIn = word[`USI_GPIO_BITS-1:0];
		idle(4);                                          // Past the synchronizer
		readReg(`USI_GPIO_BLOCK, 16'd1);
		readReg(`USI_GPIO_BLOCK, 16'd7);                  // Unused CSR
	endtask

	task automatic checkRam();
		for (int a = 0; a < `USI_RAM_DEPTH; a++)
			writeReg(`USI_RAM_BLOCK, 16'(a), randWord());
		for (int a = 0; a < `USI_RAM_DEPTH; a++)
			readReg(`USI_RAM_BLOCK, 16'(a));              // Back to back
	endtask

	task automatic checkPwm(input int p, input int d);
		int highs;
		int want;
		highs = 0;
		want  = (d < p) ? d : p;
		writeReg(`USI_PWM_BLOCK, 16'd0, 32'(p));
		writeReg(`USI_PWM_BLOCK, 16'd1, 32'(d));
		idle(p + 4);                                      // Counter into the new period
		for (int i = 0; i < p; i++)
		begin
			idle(1);
			highs += int'(pwmOut);
		end
		assert (highs == want)
			else abortRun($sformatf("FAILED at %0d ns: pwmOut high %0d of %0d, expected %0d",
				$time, highs, p, want));
		readReg(`USI_PWM_BLOCK, 16'd0);
		readReg(`USI_PWM_BLOCK, 16'd1);
	endtask

	task automatic checkUnmapped();
		readReg(8'd0, 16'd0);
		readReg(8'd9, 16'd0);
		// Ignored commands aimed at live registers
		issue(1'b1, cmdNone, `USI_GPIO_BLOCK, 16'd0, {16'hffff, ~gpioShadow});
		issue(1'b1, cmdWriteRead, `USI_GPIO_BLOCK, 16'd0, {16'hffff, ~gpioShadow});
		issue(1'b1, cmdWriteRead, `USI_RAM_BLOCK, 16'd5, ~ramShadow[5]);
		issue(1'b0, cmdWrite, `USI_RAM_BLOCK, 16'd5, ~ramShadow[5]);  // mWEd low
		readReg(`USI_GPIO_BLOCK, 16'd0);
		readReg(`USI_RAM_BLOCK, 16'd5);
		idle(2);
		checkGpioOut();
	endtask

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial
	begin
		int p;
		rstN = 1'b0;
		mWd = '0;
		mAdrs = '0;
		mWEd = 1'b0;
		gpioIn = '0;
		gpioShadow = '0;
		pwmPeriod = '0;
		pwmDuty = '0;
		idle(1);
		chkOn  = 1'b1;
		rstWin = 1'b1;
		idle(3);                                          // 4 edges in reset
		rstN = 1'b1;
		idle(1);
		rstWin = 0;

		checkGpio();
		checkRam();
		p = int'(randWord() % (MaxPeriod - MinPeriod + 1)) + MinPeriod;
		checkPwm(p, 0);
		p = int'(randWord() % (MaxPeriod - MinPeriod + 1)) + MinPeriod;
		checkPwm(p, p + int'(randWord() % 8) + 1);       // Duty past the period
		p = int'(randWord() % (MaxPeriod - MinPeriod + 1)) + MinPeriod;
		checkPwm(p, int'(randWord() % (p + 1)));
		checkUnmapped();
		idle(PipeDepth + 1);                              // Drain the model

		$display("TB PASSED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(2 * TestCycles * ClkPeriod);
		abortRun($sformatf("Timeout: test still running after %0d clock cycles",
			2 * TestCycles));
	end

endmodule

`default_nettype wire

/* hw/usiTop.sv */
// Peripheral subsystem top
// Bus block with GPIO, PWM and RAM slaves
`timescale 1ns/1ps
`default_nettype none
`include "usi_settings.svh"

module usiTop (
	input  logic                       iUsiClk,
	input  logic                       rstN,
	// Master
	input  logic [`USI_DATA_BITS-1:0]  mWd,
	input  logic [`USI_ADRS_BITS-1:0]  mAdrs,
	input  logic                       mWEd,
	output logic [`USI_DATA_BITS-1:0]  mRd,
	output logic [`USI_SLAVES-1:0]     mREd,
	// Pins
	input  logic [`USI_GPIO_BITS-1:0]  gpioIn,
	output logic [`USI_GPIO_BITS-1:0]  gpioOut,
	output logic                       pwmOut
);
	import usiPkg::*;

	// ----------------------------------------
	// Bus to slave wiring
	// ----------------------------------------
	logic [`USI_SLAVES-1:0]                      sSel;
	usiCmdE                                      sCmd;
	usiCsrT                                      sCsr;
	logic [`USI_DATA_BITS-1:0]                   sWd;
	logic [`USI_SLAVES-1:0][`USI_DATA_BITS-1:0]  sRd;   // Slot = block - 1
	logic [`USI_SLAVES-1:0]                      sREd;

	usiBus uBus (
		.iUsiClk (iUsiClk), .rstN (rstN),
		.mWd     (mWd),     .mAdrs (mAdrs), .mWEd (mWEd),
		.mRd     (mRd),     .mREd  (mREd),
		.sSel    (sSel),    .sCmd  (sCmd),  .sCsr (sCsr), .sWd (sWd),
		.sRd     (sRd),     .sREd  (sREd)
	);

	usiGpio uGpio (
		.iUsiClk (iUsiClk), .rstN (rstN),
		.sel     (sSel[`USI_GPIO_BLOCK-1]), .cmd (sCmd), .csr (sCsr), .wd (sWd),
		.rd      (sRd[`USI_GPIO_BLOCK-1]),  .rEd (sREd[`USI_GPIO_BLOCK-1]),
		.gpioIn  (gpioIn),  .gpioOut (gpioOut)
	);

	usiPwm uPwm (
		.iUsiClk (iUsiClk), .rstN (rstN),
		.sel     (sSel[`USI_PWM_BLOCK-1]), .cmd (sCmd), .csr (sCsr), .wd (sWd),
		.rd      (sRd[`USI_PWM_BLOCK-1]),  .rEd (sREd[`USI_PWM_BLOCK-1]),
		.pwmOut  (pwmOut)
	);

	usiRam uRam (
		.iUsiClk (iUsiClk), .rstN (rstN),
		.sel     (sSel[`USI_RAM_BLOCK-1]), .cmd (sCmd), .csr (sCsr), .wd (sWd),
		.rd      (sRd[`USI_RAM_BLOCK-1]),  .rEd (sREd[`USI_RAM_BLOCK-1])
	);

endmodule

`default_nettype wire

/* hw/usiRam.sv */
// RAM slave
// Word-addressed scratch memory, one-edge read
`timescale 1ns/1ps
`default_nettype none
`include "usi_settings.svh"

module usiRam (
	input  logic                       iUsiClk,
	input  logic                       rstN,
	// Bus
	input  logic                       sel,
	input  usiPkg::usiCmdE             cmd,
	input  usiPkg::usiCsrT             csr,
	input  logic [`USI_DATA_BITS-1:0]  wd,
	output logic [`USI_DATA_BITS-1:0]  rd,
	output logic                       rEd
);
	import usiPkg::*;

	localparam int IdxBits = $clog2(`USI_RAM_DEPTH);

	logic [`USI_DATA_BITS-1:0] mem [`USI_RAM_DEPTH];
	logic [IdxBits-1:0]        idx;        // Low CSR bits pick the word
	logic                      wrHit;
	logic                      rdHit;

	assign idx   = csr[IdxBits-1:0];
	assign wrHit = sel && cmd == cmdWrite;
	assign rdHit = sel && cmd == cmdRead;

	// Memory array, no reset
	always_ff @(posedge iUsiClk)
	begin
		if (wrHit)
			mem[idx] <= wd;
		if (rdHit)
			rd <= mem[idx];                  // Old word on same-edge write
	end

	// Ready pulse
	always_ff @(posedge iUsiClk)
	begin
		if (!rstN)
			rEd <= 1'b0;
		else
			rEd <= rdHit;
	end

endmodule

`default_nettype wire

/* hw/usiPwm.sv */
// PWM slave
// CSR 0 period, CSR 1 duty, CSR 2 counter readback
// Free-running counter and registered PWM output
`timescale 1ns/1ps
`default_nettype none
`include "usi_settings.svh"

module usiPwm (
	input  logic                       iUsiClk,
	input  logic                       rstN,
	// Bus
	input  logic                       sel,
	input  usiPkg::usiCmdE             cmd,
	input  usiPkg::usiCsrT             csr,
	input  logic [`USI_DATA_BITS-1:0]  wd,
	output logic [`USI_DATA_BITS-1:0]  rd,
	output logic                       rEd,
	// Output pin
	output logic                       pwmOut
);
	import usiPkg::*;

	logic [`USI_DATA_BITS-1:0] period;
	logic [`USI_DATA_BITS-1:0] duty;
	logic [`USI_DATA_BITS-1:0] cnt;    // 0 .. period-1
	logic                      wrHit;
	logic                      rdHit;
	logic                      cntWrap;

	assign wrHit = sel && cmd == cmdWrite;
	assign rdHit = sel && cmd == cmdRead;
	// Wrap at the end, also when period shrank below cnt
	assign cntWrap = (period == '0) || (cnt >= period - 1'b1);

	// ----------------------------------------
	// Registers and counter
	// ----------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (!rstN)
		begin
			period <= '0;
			duty   <= '0;
			cnt    <= '0;
			pwmOut <= 1'b0;
			rEd    <= 1'b0;
		end
		else
		begin
			rEd <= rdHit;
			if (wrHit && csr == 16'd0)
				period <= wd;
			if (wrHit && csr == 16'd1)
				duty <= wd;

			// Period 0 parks the counter at 0
			if (cntWrap)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;

			pwmOut <= cnt < duty;            // min(duty, period) highs per period
		end
	end

	// ----------------------------------------
	// Read data
	// ----------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (rdHit)
		begin
			case (csr)
				16'd0:   rd <= period;
				16'd1:   rd <= duty;
				16'd2:   rd <= cnt;
				default: rd <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/usiGpio.sv */
// GPIO slave
// CSR 0 output register, CSR 1 synchronized input port
`timescale 1ns/1ps
`default_nettype none
`include "usi_settings.svh"

module usiGpio (
	input  logic                       iUsiClk,
	input  logic                       rstN,
	// Bus
	input  logic                       sel,
	input  usiPkg::usiCmdE             cmd,
	input  usiPkg::usiCsrT             csr,
	input  logic [`USI_DATA_BITS-1:0]  wd,
	output logic [`USI_DATA_BITS-1:0]  rd,
	output logic                       rEd,
	// Pins
	input  logic [`USI_GPIO_BITS-1:0]  gpioIn,
	output logic [`USI_GPIO_BITS-1:0]  gpioOut
);
	import usiPkg::*;

	logic [`USI_GPIO_BITS-1:0] syncQ1;  // First sync stage
	logic [`USI_GPIO_BITS-1:0] syncQ2;  // Stable input value
	logic                      wrHit;
	logic                      rdHit;

	assign wrHit = sel && cmd == cmdWrite;
	assign rdHit = sel && cmd == cmdRead;

	// Two-flop input synchronizer
	always_ff @(posedge iUsiClk)
	begin
		syncQ1 <= gpioIn;
		syncQ2 <= syncQ1;
	end

	// Output register and ready pulse
	always_ff @(posedge iUsiClk)
	begin
		if (!rstN)
		begin
			gpioOut <= '0;
			rEd     <= 1'b0;
		end
		else
		begin
			rEd <= rdHit;                    // One cycle per read
			if (wrHit && csr == 16'd0)
				gpioOut <= wd[`USI_GPIO_BITS-1:0];
		end
	end

	// Read data, held between reads
	always_ff @(posedge iUsiClk)
	begin
		if (rdHit)
		begin
			case (csr)
				16'd0:   rd <= `USI_DATA_BITS'(gpioOut);
				16'd1:   rd <= `USI_DATA_BITS'(syncQ2);
				default: rd <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/usiBus.sv */
// Bus block between one master and the slaves
// Command register, block decode to one-hot select,
// read data return aligned to the block carried with the command
`timescale 1ns/1ps
`default_nettype none
`include "usi_settings.svh"

module usiBus (
	input  logic                                        iUsiClk,
	input  logic                                        rstN,
	// Master side
	input  logic [`USI_DATA_BITS-1:0]                   mWd,
	input  logic [`USI_ADRS_BITS-1:0]                   mAdrs,
	input  logic                                        mWEd,
	output logic [`USI_DATA_BITS-1:0]                   mRd,
	output logic [`USI_SLAVES-1:0]                      mREd,
	// Slave side
	output logic [`USI_SLAVES-1:0]                      sSel,
	output usiPkg::usiCmdE                              sCmd,
	output usiPkg::usiCsrT                              sCsr,
	output logic [`USI_DATA_BITS-1:0]                   sWd,
	input  logic [`USI_SLAVES-1:0][`USI_DATA_BITS-1:0]  sRd,
	input  logic [`USI_SLAVES-1:0]                      sREd
);
	import usiPkg::*;

	// ----------------------------------------
	// Command word split and decode
	// ----------------------------------------
	usiCmdE                  cmdIn;
	usiBlockT                blkIn;
	usiCsrT                  csrIn;
	logic                    cmdOk;     // Write or read issued this cycle
	logic [`USI_SLAVES-1:0]  selNext;

	assign cmdIn = usiCmdE'(mAdrs[`USI_ADRS_BITS-1 -: 2]);
	assign blkIn = mAdrs[23:16];
	assign csrIn = mAdrs[15:0];
	assign cmdOk = mWEd && (cmdIn == cmdWrite || cmdIn == cmdRead);

	// One-hot select, zero for unmapped block
	always_comb
	begin
		for (int i = 0; i < `USI_SLAVES; i++)
			selNext[i] = cmdOk && (blkIn == usiBlockT'(i + 1));
	end

	always_ff @(posedge iUsiClk)
	begin
		if (!rstN)
		begin
			sSel <= '0;
			sCmd <= cmdNone;
		end
		else
		begin
			sSel <= selNext;
			sCmd <= cmdOk ? cmdIn : cmdNone;  // Drop writeRead here
		end
		sCsr <= csrIn;                       // Payload, qualified by sSel
		sWd  <= mWd;
	end

	// ----------------------------------------
	// Response path
	// ----------------------------------------
	usiBlockT                blkQ [2];  // Block of the command in flight
	logic [1:0]              rdQ;       // Read issued, same delay
	logic [`USI_DATA_BITS-1:0] rdMux;

	// Data of the slave at the delayed block, fill if unmapped
	always_comb
	begin
		rdMux = `USI_FILL;
		for (int i = 0; i < `USI_SLAVES; i++)
			if (blkQ[1] == usiBlockT'(i + 1))
				rdMux = sRd[i];
	end

	always_ff @(posedge iUsiClk)
	begin
		blkQ[0] <= blkIn;
		blkQ[1] <= blkQ[0];
		if (!rstN)
		begin
			rdQ  <= '0;
			mREd <= '0;
			mRd  <= '0;
		end
		else
		begin
			rdQ  <= {rdQ[0], mWEd && cmdIn == cmdRead};
			mREd <= sREd;
			if (rdQ[1])
				mRd <= rdMux;                // Otherwise hold last value
		end
	end

endmodule

`default_nettype wire

/* hw/usiPkg.sv */
// Shared bus types
// Command code enum, block and CSR address fields
`default_nettype none
`include "usi_settings.svh"

package usiPkg;

	// Command code, bits 31:30 of the command word
	typedef enum logic [1:0]
	{
		cmdNone      = 2'd0,
		cmdWrite     = 2'd1,
		cmdRead      = 2'd2,
		cmdWriteRead = 2'd3    // Not supported, treated as none
	} usiCmdE;

	typedef logic [7:0]  usiBlockT;  // Block address, selects a slave
	typedef logic [15:0] usiCsrT;    // Register address inside a block

endpackage

`default_nettype wire

/* hw/usi_settings.svh */
// Bus widths and command word layout
// Block map, slave count and unmapped read fill
// GPIO width and RAM depth
`ifndef USI_SETTINGS_SVH
`define USI_SETTINGS_SVH

// Bus widths
`define USI_DATA_BITS 32          // Data word
`define USI_ADRS_BITS 32          // Command word, {31:30} cmd, {23:16} block, {15:0} csr

// Slaves behind the bus
`define USI_SLAVES 3

// Block map, slave index is block - 1
`define USI_GPIO_BLOCK 1
`define USI_PWM_BLOCK 2
`define USI_RAM_BLOCK 3

// Read data for a block nobody answers
`define USI_FILL 32'h1234_5678

// Slave sizes
`define USI_GPIO_BITS 16
`define USI_RAM_DEPTH 64

`endif
